// File: source/rename_pkg.sv
package rename_pkg;

    localparam int NUM_LREGS = 32;
    localparam int NUM_PREGS = 64;
    localparam int ROB_DEPTH = 16;

    typedef logic [$clog2(NUM_LREGS)-1:0] lreg_t;
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] robidx_t;
    typedef logic [31:0]                  pc_t;

    // major opcodes handled by the rename front
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_32  = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // register-register and store layout
    typedef struct packed {
        logic [6:0] funct7;
        lreg_t      rs2;
        lreg_t      rs1;
        logic [2:0] funct3;
        lreg_t      rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        lreg_t       rs1;
        logic [2:0]  funct3;
        lreg_t       rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        pc_t   pc;
        lreg_t lrs1;
        lreg_t lrs2;
        lreg_t lrd;
        logic  src1_is_reg;
        logic  src2_is_reg;
        logic  need_to_wb;
    } decoded_op_t;

    typedef struct packed {
        pc_t     pc;
        lreg_t   lrd;
        preg_t   prs1;
        preg_t   prs2;
        preg_t   prd;
        preg_t   old_prd;
        logic    need_to_wb;
        robidx_t robidx;
    } renamed_op_t;

    typedef struct packed {
        pc_t   pc;
        lreg_t lrd;
        preg_t prd;
        preg_t old_prd;
        logic  need_to_wb;
    } commit_t;

endpackage

// File: source/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        instr_valid,
    input  instr_u      instr,
    input  pc_t         instr_pc,
    output logic        dec_valid,
    output decoded_op_t dec_op
);

    logic [6:0]  opcode;
    decoded_op_t dec_next;

    // opcode sits in the same bits for both layouts
    assign opcode = instr.r_fmt.opcode;

    always_comb begin
        dec_next    = '0;
        dec_next.pc = instr_pc;
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                dec_next.lrs1        = instr.r_fmt.rs1;
                dec_next.lrs2        = instr.r_fmt.rs2;
                dec_next.lrd         = instr.r_fmt.rd;
                dec_next.src1_is_reg = 1'b1;
                dec_next.src2_is_reg = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                dec_next.lrs1        = instr.i_fmt.rs1;
                dec_next.lrd         = instr.i_fmt.rd;
                dec_next.src1_is_reg = 1'b1;
            end
            OPC_STORE: begin
                // rd bits hold immediate here and there is no destination
                dec_next.lrs1        = instr.r_fmt.rs1;
                dec_next.lrs2        = instr.r_fmt.rs2;
                dec_next.src1_is_reg = 1'b1;
                dec_next.src2_is_reg = 1'b1;
            end
            default: begin
                // no sources and no destination
            end
        endcase
        // x0 is never renamed
        dec_next.need_to_wb = (dec_next.lrd != '0);
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (instr_valid) begin
            dec_op <= dec_next;
        end
    end

endmodule

// File: source/rename_table.sv
`timescale 1ns/1ps

module rename_table
    import rename_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  lreg_t rd_lreg1,
    input  lreg_t rd_lreg2,
    input  lreg_t wr_lreg,
    output preg_t rd_preg1,
    output preg_t rd_preg2,
    output preg_t old_preg,
    input  logic  wr_en,
    input  preg_t wr_preg
);

    preg_t map_q [NUM_LREGS];

    // reads see the table before this cycle's write
    assign rd_preg1 = map_q[rd_lreg1];
    assign rd_preg2 = map_q[rd_lreg2];
    assign old_preg = map_q[wr_lreg];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // identity mapping out of reset
            for (int i = 0; i < NUM_LREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (wr_en) begin
            map_q[wr_lreg] <= wr_preg;
        end
    end

    // the decoder must never let x0 through as a destination
    a_x0_pinned: assert property (
        @(posedge clock) disable iff (!reset_n)
        map_q[0] == '0
    );

endmodule

// File: source/free_list.sv
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic  clock,
    input  logic  reset_n,
    input  logic  alloc_en,
    output preg_t alloc_preg,
    input  logic  release_en,
    input  preg_t release_preg
);

    localparam int FL_DEPTH = NUM_PREGS - NUM_LREGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    preg_t               slots [FL_DEPTH];
    logic [FL_PTR_W-1:0] head;
    logic [FL_PTR_W-1:0] tail;
    logic [FL_PTR_W:0]   count;

    assign alloc_preg = slots[head];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // pregs above the logical range start out free
            for (int i = 0; i < FL_DEPTH; i++) begin
                slots[i] <= preg_t'(NUM_LREGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (FL_PTR_W + 1)'(FL_DEPTH);
        end else begin
            if (alloc_en) begin
                head <= head + 1'b1;
            end
            if (release_en) begin
                slots[tail] <= release_preg;
                tail        <= tail + 1'b1;
            end
            case ({alloc_en, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_alloc_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        alloc_en |-> count != '0
    );

    // a full list means some preg was freed twice
    a_no_release_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        release_en |-> count != (FL_PTR_W + 1)'(FL_DEPTH)
    );

endmodule

// File: source/rename_stage.sv
`timescale 1ns/1ps

module rename_stage
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        dec_valid,
    input  decoded_op_t dec_op,
    input  logic        commit_valid,
    input  commit_t     commit_op,
    output logic        issue_valid,
    output renamed_op_t issue_op
);

    preg_t       rat_prs1;
    preg_t       rat_prs2;
    preg_t       rat_old_prd;
    preg_t       free_preg;
    logic        alloc;
    logic        release_old;
    robidx_t     next_robidx;
    renamed_op_t renamed_next;

    assign alloc       = dec_valid & dec_op.need_to_wb;
    assign release_old = commit_valid & commit_op.need_to_wb;

    rename_table u_rename_table (
        .clock    (clock),
        .reset_n  (reset_n),
        .rd_lreg1 (dec_op.lrs1),
        .rd_lreg2 (dec_op.lrs2),
        .wr_lreg  (dec_op.lrd),
        .rd_preg1 (rat_prs1),
        .rd_preg2 (rat_prs2),
        .old_preg (rat_old_prd),
        .wr_en    (alloc),
        .wr_preg  (free_preg)
    );

    free_list u_free_list (
        .clock        (clock),
        .reset_n      (reset_n),
        .alloc_en     (alloc),
        .alloc_preg   (free_preg),
        .release_en   (release_old),
        .release_preg (commit_op.old_prd)
    );

    always_comb begin
        renamed_next.pc         = dec_op.pc;
        renamed_next.lrd        = dec_op.lrd;
        renamed_next.prs1       = dec_op.src1_is_reg ? rat_prs1 : '0;
        renamed_next.prs2       = dec_op.src2_is_reg ? rat_prs2 : '0;
        // ops without a destination carry preg 0 in both fields
        renamed_next.prd        = dec_op.need_to_wb ? free_preg : '0;
        renamed_next.old_prd    = dec_op.need_to_wb ? rat_old_prd : '0;
        renamed_next.need_to_wb = dec_op.need_to_wb;
        renamed_next.robidx     = next_robidx;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= 1'b0;
            next_robidx <= '0;
        end else begin
            issue_valid <= dec_valid;
            if (dec_valid) begin
                next_robidx <= next_robidx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dec_valid) begin
            issue_op <= renamed_next;
        end
    end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        enq_valid,
    input  renamed_op_t enq_op,
    input  logic        writeback_valid,
    input  robidx_t     writeback_robidx,
    output logic        commit_valid,
    output commit_t     commit_op
);

    commit_t              entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] entry_valid;
    logic [ROB_DEPTH-1:0] entry_done;
    robidx_t              head;
    robidx_t              tail;
    logic                 can_commit;
    commit_t              enq_entry;

    assign can_commit = entry_valid[head] & entry_done[head];

    always_comb begin
        enq_entry.pc         = enq_op.pc;
        enq_entry.lrd        = enq_op.lrd;
        enq_entry.prd        = enq_op.prd;
        enq_entry.old_prd    = enq_op.old_prd;
        enq_entry.need_to_wb = enq_op.need_to_wb;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid  <= '0;
            entry_done   <= '0;
            head         <= '0;
            tail         <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= can_commit;
            if (can_commit) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            if (writeback_valid) begin
                entry_done[writeback_robidx] <= 1'b1;
            end
            // enqueue last so a fresh entry starts not done
            if (enq_valid) begin
                entry_valid[enq_op.robidx] <= 1'b1;
                entry_done[enq_op.robidx]  <= 1'b0;
                tail                       <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            entries[enq_op.robidx] <= enq_entry;
        end
        if (can_commit) begin
            commit_op <= entries[head];
        end
    end

    a_no_enq_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        enq_valid |-> !entry_valid[tail]
    );

    // rename stamps robidx on its own, so it must track our tail
    a_enq_at_tail: assert property (
        @(posedge clock) disable iff (!reset_n)
        enq_valid |-> enq_op.robidx == tail
    );

    a_wb_live_entry: assert property (
        @(posedge clock) disable iff (!reset_n)
        writeback_valid |-> entry_valid[writeback_robidx]
    );

endmodule

// File: source/rename_core.sv
`timescale 1ns/1ps

module rename_core
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        instr_valid,
    input  instr_u      instr,
    input  pc_t         instr_pc,
    input  logic        writeback_valid,
    input  robidx_t     writeback_robidx,
    output logic        issue_valid,
    output renamed_op_t issue_op,
    output logic        commit_valid,
    output commit_t     commit_op
);

    logic        dec_valid;
    decoded_op_t dec_op;

    instr_decode u_instr_decode (
        .clock       (clock),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op)
    );

    // commit feeds back into rename to free old_prd
    rename_stage u_rename_stage (
        .clock        (clock),
        .reset_n      (reset_n),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .commit_valid (commit_valid),
        .commit_op    (commit_op),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op)
    );

    reorder_buffer u_reorder_buffer (
        .clock            (clock),
        .reset_n          (reset_n),
        .enq_valid        (issue_valid),
        .enq_op           (issue_op),
        .writeback_valid  (writeback_valid),
        .writeback_robidx (writeback_robidx),
        .commit_valid     (commit_valid),
        .commit_op        (commit_op)
    );

endmodule

// File: sim/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb
    import rename_pkg::*;
();

    localparam int NUM_DIRECTED  = 6;
    localparam int NUM_RANDOM    = 80;
    localparam int NUM_INSTRS    = NUM_DIRECTED + NUM_RANDOM;
    localparam int MAX_IN_FLIGHT = 12;
    // 86 ops at about 4 cycles each, plus drain, stay far below this
    localparam int MAX_CYCLES    = 3000;

    typedef struct packed {
        logic [31:0] word;
        pc_t         pc;
        logic [31:0] strobe_cycle;
    } sent_instr_t;

    typedef struct packed {
        commit_t op;
        robidx_t robidx;
    } rob_entry_t;

    logic        clock;
    logic        reset_n;
    logic        instr_valid;
    instr_u      instr;
    pc_t         instr_pc;
    logic        writeback_valid;
    robidx_t     writeback_robidx;
    logic        issue_valid;
    renamed_op_t issue_op;
    logic        commit_valid;
    commit_t     commit_op;

    // model state
    preg_t       model_map [NUM_LREGS];
    preg_t       model_free [$];
    robidx_t     model_robidx;
    sent_instr_t sent_q [$];
    rob_entry_t  rob_q [$];
    robidx_t     wb_list [$];
    int unsigned wb_cycle [ROB_DEPTH];
    int unsigned cycle;
    int          n_sent;
    int          n_issued;
    int          n_committed;
    int          n_allocs;

    rename_core dut0 (
        .clock            (clock),
        .reset_n          (reset_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .writeback_valid  (writeback_valid),
        .writeback_robidx (writeback_robidx),
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .commit_valid     (commit_valid),
        .commit_op        (commit_op)
    );

    always #4 clock = ~clock;

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [31:0] encode_instr(logic [6:0] opc, lreg_t rd, lreg_t rs1,
                                                 lreg_t rs2, logic [9:0] filler);
        return {filler[9:3], rs2, rs1, filler[2:0], rd, opc};
    endfunction

    // first few ops are fixed, the rest random
    function automatic logic [31:0] next_instr(int idx);
        logic [6:0] opc;
        lreg_t      rd;
        case (idx)
            0: return encode_instr(OPC_OP, 5'd5, 5'd1, 5'd2, 10'h000);
            // depends on the op just before, rs2 bits are immediate
            1: return encode_instr(OPC_OP_IMM, 5'd6, 5'd5, 5'd17, 10'h155);
            // rd bits are immediate for a store
            2: return encode_instr(OPC_STORE, 5'd9, 5'd6, 5'd5, 10'h000);
            3: return encode_instr(7'h7f, 5'd3, 5'd4, 5'd5, 10'h000);
            4: return encode_instr(OPC_OP, 5'd0, 5'd3, 5'd4, 10'h000);
            5: return encode_instr(OPC_LOAD, 5'd5, 5'd6, 5'd0, 10'h2aa);
            default: begin
                case ($urandom_range(0, 5))
                    0: opc = OPC_OP;
                    1: opc = OPC_OP_32;
                    2: opc = OPC_OP_IMM;
                    3: opc = OPC_LOAD;
                    4: opc = OPC_STORE;
                    default: opc = 7'h7f;
                endcase
                rd = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
                return encode_instr(opc, rd, 5'($urandom_range(0, 31)),
                                    5'($urandom_range(0, 31)), 10'($urandom));
            end
        endcase
    endfunction

    function automatic decoded_op_t ref_decode(logic [31:0] word, pc_t pc);
        decoded_op_t d;
        logic [6:0]  opc;
        d    = '0;
        d.pc = pc;
        opc  = word[6:0];
        if (opc == OPC_OP || opc == OPC_OP_32) begin
            d.lrs1        = word[19:15];
            d.lrs2        = word[24:20];
            d.lrd         = word[11:7];
            d.src1_is_reg = 1'b1;
            d.src2_is_reg = 1'b1;
        end else if (opc == OPC_OP_IMM || opc == OPC_LOAD) begin
            d.lrs1        = word[19:15];
            d.lrd         = word[11:7];
            d.src1_is_reg = 1'b1;
        end else if (opc == OPC_STORE) begin
            d.lrs1        = word[19:15];
            d.lrs2        = word[24:20];
            d.src1_is_reg = 1'b1;
            d.src2_is_reg = 1'b1;
        end
        d.need_to_wb = (d.lrd != 5'd0);
        return d;
    endfunction

    // computes the expected issue and advances the model table, free FIFO and robidx
    function automatic renamed_op_t ref_rename(decoded_op_t d);
        renamed_op_t r;
        r.pc         = d.pc;
        r.lrd        = d.lrd;
        r.prs1       = d.src1_is_reg ? model_map[d.lrs1] : 6'd0;
        r.prs2       = d.src2_is_reg ? model_map[d.lrs2] : 6'd0;
        r.prd        = 6'd0;
        r.old_prd    = 6'd0;
        r.need_to_wb = d.need_to_wb;
        r.robidx     = model_robidx;
        if (d.need_to_wb) begin
            r.prd            = model_free.pop_front();
            r.old_prd        = model_map[d.lrd];
            model_map[d.lrd] = r.prd;
            n_allocs++;
        end
        model_robidx = model_robidx + 1'b1;
        return r;
    endfunction

    task automatic check_issue();
        sent_instr_t s;
        renamed_op_t exp;
        rob_entry_t  e;
        assert (sent_q.size() > 0) else begin
            $display("Error at %0d ns: issue_valid high with no instruction pending", $time);
            stop_run();
        end
        s   = sent_q.pop_front();
        exp = ref_rename(ref_decode(s.word, s.pc));
        if (n_issued == 0) begin
            check_value("issue_op.prd of first op", 32'd32, 32'(issue_op.prd));
        end
        check_value("issue_valid cycle", s.strobe_cycle + 2, cycle);
        check_value("issue_op.pc", exp.pc, issue_op.pc);
        check_value("issue_op.lrd", 32'(exp.lrd), 32'(issue_op.lrd));
        check_value("issue_op.prs1", 32'(exp.prs1), 32'(issue_op.prs1));
        check_value("issue_op.prs2", 32'(exp.prs2), 32'(issue_op.prs2));
        check_value("issue_op.prd", 32'(exp.prd), 32'(issue_op.prd));
        check_value("issue_op.old_prd", 32'(exp.old_prd), 32'(issue_op.old_prd));
        check_value("issue_op.need_to_wb", 32'(exp.need_to_wb), 32'(issue_op.need_to_wb));
        check_value("issue_op.robidx", 32'(exp.robidx), 32'(issue_op.robidx));
        e.op     = {exp.pc, exp.lrd, exp.prd, exp.old_prd, exp.need_to_wb};
        e.robidx = exp.robidx;
        rob_q.push_back(e);
        wb_list.push_back(exp.robidx);
        n_issued++;
    endtask

    task automatic check_commit();
        rob_entry_t e;
        assert (rob_q.size() > 0) else begin
            $display("Error at %0d ns: commit_valid high with no op in flight", $time);
            stop_run();
        end
        e = rob_q.pop_front();
        assert (wb_cycle[e.robidx] != 0) else begin
            $display("Error at %0d ns: entry %0d committed before its writeback",
                     $time, e.robidx);
            stop_run();
        end
        // done is set on the writeback edge, commit_valid is registered after it
        assert (cycle >= wb_cycle[e.robidx] + 2) else begin
            $display("Error at %0d ns: entry %0d committed within 2 cycles of its writeback",
                     $time, e.robidx);
            stop_run();
        end
        wb_cycle[e.robidx] = 0;
        check_value("commit_op.pc", e.op.pc, commit_op.pc);
        check_value("commit_op.lrd", 32'(e.op.lrd), 32'(commit_op.lrd));
        check_value("commit_op.prd", 32'(e.op.prd), 32'(commit_op.prd));
        check_value("commit_op.old_prd", 32'(e.op.old_prd), 32'(commit_op.old_prd));
        check_value("commit_op.need_to_wb", 32'(e.op.need_to_wb),
                    32'(commit_op.need_to_wb));
        // freed preg goes to the tail of the model FIFO
        if (e.op.need_to_wb) begin
            model_free.push_back(e.op.old_prd);
        end
        n_committed++;
    endtask

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clock) begin
        cycle = cycle + 1;
        assert (cycle < MAX_CYCLES) else begin
            $display("Error at %0d ns: run did not finish within %0d cycles",
                     $time, MAX_CYCLES);
            stop_run();
        end
        if (reset_n && issue_valid) begin
            check_issue();
        end
        if (reset_n && commit_valid) begin
            check_commit();
        end
    end

    initial begin
        sent_instr_t s;
        int          pick;
        clock            = 1'b0;
        reset_n          = 1'b0;
        instr_valid      = 1'b0;
        instr            = '0;
        instr_pc         = '0;
        writeback_valid  = 1'b0;
        writeback_robidx = '0;
        cycle            = 0;
        n_sent           = 0;
        n_issued         = 0;
        n_committed      = 0;
        n_allocs         = 0;
        model_robidx     = '0;
        void'($urandom(48));
        for (int i = 0; i < NUM_LREGS; i++) begin
            model_map[i] = preg_t'(i);
            model_free.push_back(preg_t'(NUM_LREGS + i));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            wb_cycle[i] = 0;
        end

        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        while (n_committed < NUM_INSTRS) begin
            @(posedge clock);
            if (n_sent < NUM_INSTRS && n_sent - n_committed < MAX_IN_FLIGHT &&
                    (n_sent < NUM_DIRECTED || $urandom_range(0, 3) != 0)) begin
                s.word         = next_instr(n_sent);
                s.pc           = 32'h1000 + 32'(4 * n_sent);
                s.strobe_cycle = cycle + 1;
                sent_q.push_back(s);
                instr_valid <= 1'b1;
                instr       <= s.word;
                instr_pc    <= s.pc;
                n_sent++;
            end else begin
                instr_valid <= 1'b0;
            end
            // writebacks in random order among the issued ops
            if (wb_list.size() > 0 && $urandom_range(0, 2) != 0) begin
                pick = $urandom_range(0, wb_list.size() - 1);
                wb_cycle[wb_list[pick]] = cycle + 1;
                writeback_robidx <= wb_list[pick];
                writeback_valid  <= 1'b1;
                wb_list.delete(pick);
            end else begin
                writeback_valid <= 1'b0;
            end
        end

        // idle cycles let a stray strobe trip the compare process
        repeat (8) @(posedge clock);
        assert (n_allocs > NUM_PREGS - NUM_LREGS) else begin
            $display("Error at %0d ns: free list never wrapped, only %0d allocations",
                     $time, n_allocs);
            stop_run();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: build.f
source/rename_pkg.sv
source/instr_decode.sv
source/rename_table.sv
source/free_list.sv
source/rename_stage.sv
source/reorder_buffer.sv
source/rename_core.sv
sim/rename_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module rename_core_tb -o rename_core_sim &&
{ ./obj_dir/rename_core_sim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "PASS: all tests" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
